// File: rtl/miniCorePkg.sv
/*
  Shared widths, depths and encodings of the RV32I back end
  Only the listed major opcodes are executed and any other one decodes as a bubble
  InBufDepth must stay a power of two so the buffer pointers wrap on their own
*/
package miniCorePkg;

  // ==============================
  // Data path widths
  // ==============================
  localparam int XLen = 32;

  typedef logic [XLen-1:0] xlenT;  // Register values, PC, immediates
  typedef logic [4:0]      regAddrT;

  // ==============================
  // Buffer and credit depths
  // ==============================
  localparam int InBufDepth = 2;   // Decode buffer slots, sender credits after reset
  localparam int InBufPtrW  = $clog2(InBufDepth);
  localparam int OutCredits = 4;   // Records the consumer can absorb
  localparam int OutCntW    = $clog2(OutCredits + 1);

  typedef logic [InBufPtrW-1:0] bufPtrT;
  typedef logic [InBufPtrW:0]   bufCntT;   // One extra bit to hold a full count
  typedef logic [OutCntW-1:0]   outCntT;

  // ==============================
  // Encodings
  // ==============================
  typedef enum logic [6:0] {
    OpReg    = 7'b0110011,  // R-type ALU
    OpImm    = 7'b0010011,  // I-type ALU
    OpLui    = 7'b0110111,
    OpAuipc  = 7'b0010111,
    OpBranch = 7'b1100011
  } opcodeT;

  typedef enum logic [3:0] {
    AluAdd,
    AluSub,
    AluSlt,
    AluSltu,
    AluSll,
    AluSrl,
    AluSra,
    AluXor,
    AluOr,
    AluAnd
  } aluOpT;

  typedef enum logic [2:0] {
    BrNone,   // Not a branch
    BrEq,
    BrNe,
    BrLt,
    BrGe,
    BrLtu,
    BrGeu
  } branchOpT;

endpackage

// File: rtl/miniCoreRegFile.sv
`timescale 1ns/100ps
/*
  32-entry register file with x0 hard-wired to zero
  A write is visible on the read ports in the same cycle
*/
module miniCoreRegFile (
  input  logic                 Clock,
  input  logic                 rstN,
  input  miniCorePkg::regAddrT rdAddr1,
  input  miniCorePkg::regAddrT rdAddr2,
  input  logic                 wrEn,
  input  miniCorePkg::regAddrT wrAddr,
  input  miniCorePkg::xlenT    wrData,
  output miniCorePkg::xlenT    rdData1,
  output miniCorePkg::xlenT    rdData2
);

  miniCorePkg::xlenT regs [1:31];  // x0 has no storage

  always_ff @(posedge Clock) begin
    if (!rstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;  // Writes to x0 dropped
    end
  end

  // Read ports with write bypass
  assign rdData1 = (rdAddr1 == '0)                  ? '0     :
                   (wrEn && (wrAddr == rdAddr1))    ? wrData :  // Same-cycle write
                                                      regs[rdAddr1];

  assign rdData2 = (rdAddr2 == '0)                  ? '0     :
                   (wrEn && (wrAddr == rdAddr2))    ? wrData :
                                                      regs[rdAddr2];

endmodule

// File: rtl/miniCoreDecode.sv
`timescale 1ns/100ps
/*
  Two-entry instruction buffer whose head is the Q101 stage
  The sender holds one credit per free slot and an overflow is not checked here
  instCredit is a registered pulse, one cycle after the head leaves
  Unsupported opcodes and reserved branch funct3 values leave as bubbles
*/
module miniCoreDecode (
  input  logic                  Clock,
  input  logic                  rstN,
  input  logic                  instValid,
  input  miniCorePkg::xlenT     inst,
  input  miniCorePkg::xlenT     instPc,
  input  logic                  ready,
  input  miniCorePkg::xlenT     rfData1,
  input  miniCorePkg::xlenT     rfData2,
  output logic                  instCredit,
  output miniCorePkg::regAddrT  rfAddr1,
  output miniCorePkg::regAddrT  rfAddr2,
  output logic                  validQ102H,
  output miniCorePkg::xlenT     pcQ102H,
  output miniCorePkg::xlenT     immQ102H,
  output miniCorePkg::xlenT     preRegRdData1Q102H,
  output miniCorePkg::xlenT     preRegRdData2Q102H,
  output miniCorePkg::regAddrT  regSrc1Q102H,
  output miniCorePkg::regAddrT  regSrc2Q102H,
  output miniCorePkg::regAddrT  regDstQ102H,
  output logic                  regWrEnQ102H,
  output miniCorePkg::aluOpT    aluOpQ102H,
  output miniCorePkg::branchOpT branchOpQ102H,
  output logic                  selAluPcQ102H,
  output logic                  selAluImmQ102H,
  output logic                  luiQ102H
);

  miniCorePkg::xlenT     bufInst [miniCorePkg::InBufDepth];
  miniCorePkg::xlenT     bufPc   [miniCorePkg::InBufDepth];
  miniCorePkg::bufPtrT   wrPtr, rdPtr;
  miniCorePkg::bufCntT   bufCnt;
  logic                  pop;
  miniCorePkg::xlenT     headInst, immI, immU, immB, imm;
  miniCorePkg::opcodeT   opcode;
  miniCorePkg::aluOpT    aluOp;
  miniCorePkg::branchOpT branchOp;
  logic                  legal, wrEn, selPc, selImm, lui;

  // ==============================
  // Instruction buffer
  // ==============================
  assign pop = ready && (bufCnt != '0);  // Head moves on to Q102

  always_ff @(posedge Clock) begin
    if (!rstN) begin
      wrPtr      <= '0;
      rdPtr      <= '0;
      bufCnt     <= '0;
      instCredit <= 1'b0;
    end else begin
      if (instValid) wrPtr <= wrPtr + 1'b1;
      if (pop)       rdPtr <= rdPtr + 1'b1;
      case ({instValid, pop})
        2'b10:   bufCnt <= bufCnt + 1'b1;
        2'b01:   bufCnt <= bufCnt - 1'b1;
        default: ;                        // Push and pop cancel out
      endcase
      instCredit <= pop;                  // Slot freed
    end
  end

  always_ff @(posedge Clock) begin
    if (instValid) begin
      bufInst[wrPtr] <= inst;
      bufPc[wrPtr]   <= instPc;
    end
  end

  // ==============================
  // Q101 decode
  // ==============================
  assign headInst = bufInst[rdPtr];
  assign opcode   = miniCorePkg::opcodeT'(headInst[6:0]);
  assign rfAddr1  = headInst[19:15];
  assign rfAddr2  = headInst[24:20];

  assign immI = {{20{headInst[31]}}, headInst[31:20]};
  assign immU = {headInst[31:12], 12'b0};
  assign immB = {{19{headInst[31]}}, headInst[31], headInst[7], headInst[30:25],
                 headInst[11:8], 1'b0};

  // funct3 and bit 30 to ALU op, SUB only for register ops
  function automatic miniCorePkg::aluOpT aluDecode(input logic [2:0] f3, input logic alt,
                                                   input logic isReg);
    case (f3)
      3'b000:  return (alt && isReg) ? miniCorePkg::AluSub : miniCorePkg::AluAdd;
      3'b001:  return miniCorePkg::AluSll;
      3'b010:  return miniCorePkg::AluSlt;
      3'b011:  return miniCorePkg::AluSltu;
      3'b100:  return miniCorePkg::AluXor;
      3'b101:  return alt ? miniCorePkg::AluSra : miniCorePkg::AluSrl;
      3'b110:  return miniCorePkg::AluOr;
      default: return miniCorePkg::AluAnd;
    endcase
  endfunction

  always_comb begin
    legal    = 1'b1;
    wrEn     = 1'b0;
    selPc    = 1'b0;
    selImm   = 1'b0;
    lui      = 1'b0;
    imm      = immI;
    aluOp    = miniCorePkg::AluAdd;  // Also the target adder for branches
    branchOp = miniCorePkg::BrNone;
    case (opcode)
      miniCorePkg::OpReg: begin
        wrEn  = 1'b1;
        aluOp = aluDecode(headInst[14:12], headInst[30], 1'b1);
      end
      miniCorePkg::OpImm: begin
        wrEn   = 1'b1;
        selImm = 1'b1;
        aluOp  = aluDecode(headInst[14:12], headInst[30], 1'b0);
      end
      miniCorePkg::OpLui: begin
        wrEn   = 1'b1;
        selImm = 1'b1;
        lui    = 1'b1;
        imm    = immU;
      end
      miniCorePkg::OpAuipc: begin
        wrEn   = 1'b1;
        selPc  = 1'b1;
        selImm = 1'b1;
        imm    = immU;
      end
      miniCorePkg::OpBranch: begin
        selPc  = 1'b1;
        selImm = 1'b1;
        imm    = immB;
        case (headInst[14:12])
          3'b000:  branchOp = miniCorePkg::BrEq;
          3'b001:  branchOp = miniCorePkg::BrNe;
          3'b100:  branchOp = miniCorePkg::BrLt;
          3'b101:  branchOp = miniCorePkg::BrGe;
          3'b110:  branchOp = miniCorePkg::BrLtu;
          3'b111:  branchOp = miniCorePkg::BrGeu;
          default: legal    = 1'b0;   // Reserved funct3
        endcase
      end
      default: legal = 1'b0;          // Bubble
    endcase
  end

  // ==============================
  // Q101 to Q102 registers
  // ==============================
  always_ff @(posedge Clock) begin
    if (!rstN) begin
      validQ102H   <= 1'b0;
      regWrEnQ102H <= 1'b0;
    end else if (ready) begin
      validQ102H   <= pop && legal;         // Empty buffer gives a bubble
      regWrEnQ102H <= pop && legal && wrEn;
    end
  end

  always_ff @(posedge Clock) begin
    if (ready) begin
      pcQ102H            <= bufPc[rdPtr];
      immQ102H           <= imm;
      preRegRdData1Q102H <= rfData1;        // Forwarding fixes these up at Q102
      preRegRdData2Q102H <= rfData2;
      regSrc1Q102H       <= rfAddr1;
      regSrc2Q102H       <= rfAddr2;
      regDstQ102H        <= headInst[11:7];
      aluOpQ102H         <= aluOp;
      branchOpQ102H      <= branchOp;
      selAluPcQ102H      <= selPc;
      selAluImmQ102H     <= selImm;
      luiQ102H           <= lui;
    end
  end

endmodule

// File: rtl/miniCoreExe.sv
`timescale 1ns/100ps
/*
  Q102 execute with forwarding from Q103 and Q104
  The Q104 write stays stable during a stall, so forwarding from it holds too
  A branch sends PC plus immediate through the ALU as its target
*/
module miniCoreExe (
  input  logic                  Clock,
  input  logic                  rstN,
  input  logic                  ready,
  input  logic                  validQ102H,
  input  miniCorePkg::xlenT     pcQ102H,
  input  miniCorePkg::xlenT     immQ102H,
  input  miniCorePkg::xlenT     preRegRdData1Q102H,
  input  miniCorePkg::xlenT     preRegRdData2Q102H,
  input  miniCorePkg::regAddrT  regSrc1Q102H,
  input  miniCorePkg::regAddrT  regSrc2Q102H,
  input  miniCorePkg::regAddrT  regDstQ102H,
  input  logic                  regWrEnQ102H,
  input  miniCorePkg::aluOpT    aluOpQ102H,
  input  miniCorePkg::branchOpT branchOpQ102H,
  input  logic                  selAluPcQ102H,
  input  logic                  selAluImmQ102H,
  input  logic                  luiQ102H,
  input  miniCorePkg::regAddrT  regDstQ104H,
  input  logic                  regWrEnQ104H,
  input  miniCorePkg::xlenT     regWrDataQ104H,
  output logic                  validQ103H,
  output miniCorePkg::xlenT     aluOutQ103H,
  output miniCorePkg::regAddrT  regDstQ103H,
  output logic                  regWrEnQ103H,
  output logic                  isBranchQ103H,
  output logic                  branchCondMetQ103H
);

  logic              hazQ103Src1, hazQ104Src1, hazQ103Src2, hazQ104Src2;
  miniCorePkg::xlenT regRdData1, regRdData2, aluIn1, aluIn2, aluOut;
  logic [4:0]        shamt;
  logic              condMet;

  // ==============================
  // Hazards and forwarding
  // ==============================
  assign hazQ103Src1 = regWrEnQ103H && (regSrc1Q102H == regDstQ103H) && (regSrc1Q102H != '0);
  assign hazQ104Src1 = regWrEnQ104H && (regSrc1Q102H == regDstQ104H) && (regSrc1Q102H != '0);
  assign hazQ103Src2 = regWrEnQ103H && (regSrc2Q102H == regDstQ103H) && (regSrc2Q102H != '0);
  assign hazQ104Src2 = regWrEnQ104H && (regSrc2Q102H == regDstQ104H) && (regSrc2Q102H != '0);

  assign regRdData1 = hazQ103Src1 ? aluOutQ103H    :  // Newest writer first
                      hazQ104Src1 ? regWrDataQ104H :
                                    preRegRdData1Q102H;
  assign regRdData2 = hazQ103Src2 ? aluOutQ103H    :
                      hazQ104Src2 ? regWrDataQ104H :
                                    preRegRdData2Q102H;

  assign aluIn1 = selAluPcQ102H  ? pcQ102H  : regRdData1;  // AUIPC and branches
  assign aluIn2 = selAluImmQ102H ? immQ102H : regRdData2;
  assign shamt  = aluIn2[4:0];                             // Low 5 bits only

  // ==============================
  // ALU
  // ==============================
  always_comb begin
    case (aluOpQ102H)
      miniCorePkg::AluSub:  aluOut = aluIn1 - aluIn2;
      miniCorePkg::AluSlt:  aluOut = {31'b0, $signed(aluIn1) < $signed(aluIn2)};
      miniCorePkg::AluSltu: aluOut = {31'b0, aluIn1 < aluIn2};
      miniCorePkg::AluSll:  aluOut = aluIn1 << shamt;
      miniCorePkg::AluSrl:  aluOut = aluIn1 >> shamt;
      miniCorePkg::AluSra:  aluOut = $signed(aluIn1) >>> shamt;
      miniCorePkg::AluXor:  aluOut = aluIn1 ^ aluIn2;
      miniCorePkg::AluOr:   aluOut = aluIn1 | aluIn2;
      miniCorePkg::AluAnd:  aluOut = aluIn1 & aluIn2;
      default:              aluOut = aluIn1 + aluIn2;  // ADD, AUIPC, branch target
    endcase
    if (luiQ102H) aluOut = aluIn2;                     // LUI passes the U-immediate
  end

  // Branch compare on the forwarded register values
  always_comb begin
    case (branchOpQ102H)
      miniCorePkg::BrEq:  condMet = (regRdData1 == regRdData2);
      miniCorePkg::BrNe:  condMet = (regRdData1 != regRdData2);
      miniCorePkg::BrLt:  condMet = ($signed(regRdData1) < $signed(regRdData2));
      miniCorePkg::BrGe:  condMet = ($signed(regRdData1) >= $signed(regRdData2));
      miniCorePkg::BrLtu: condMet = (regRdData1 < regRdData2);
      miniCorePkg::BrGeu: condMet = (regRdData1 >= regRdData2);
      default:            condMet = 1'b0;
    endcase
  end

  // ==============================
  // Q102 to Q103 registers
  // ==============================
  always_ff @(posedge Clock) begin
    if (!rstN) begin
      validQ103H   <= 1'b0;
      regWrEnQ103H <= 1'b0;
    end else if (ready) begin
      validQ103H   <= validQ102H;
      regWrEnQ103H <= regWrEnQ102H;  // Already low for bubbles
    end
  end

  always_ff @(posedge Clock) begin
    if (ready) begin
      aluOutQ103H        <= aluOut;
      regDstQ103H        <= regDstQ102H;
      isBranchQ103H      <= validQ102H && (branchOpQ102H != miniCorePkg::BrNone);
      branchCondMetQ103H <= condMet;
    end
  end

endmodule

// File: rtl/miniCoreResult.sv
`timescale 1ns/100ps
/*
  Q104 result stage with output credits and the core ready
  A credit is spent in the cycle the record is presented
  While stalled Q104 keeps its write, which only rewrites the same value
*/
module miniCoreResult (
  input  logic                 Clock,
  input  logic                 rstN,
  input  logic                 resultCreditReturn,
  input  logic                 validQ103H,
  input  miniCorePkg::xlenT    aluOutQ103H,
  input  miniCorePkg::regAddrT regDstQ103H,
  input  logic                 regWrEnQ103H,
  input  logic                 isBranchQ103H,
  input  logic                 branchCondMetQ103H,
  output logic                 ready,
  output miniCorePkg::regAddrT regDstQ104H,
  output logic                 regWrEnQ104H,
  output miniCorePkg::xlenT    regWrDataQ104H,
  output logic                 resultValid,
  output miniCorePkg::regAddrT resultRd,
  output miniCorePkg::xlenT    resultData,
  output logic                 resultIsBranch,
  output logic                 resultTaken,
  output miniCorePkg::xlenT    resultTarget
);

  miniCorePkg::outCntT creditCnt;
  logic                creditOk, send;

  // ==============================
  // Output credits and ready
  // ==============================
  // A credit must be left after the record now on the output
  assign creditOk = resultValid ? (creditCnt > miniCorePkg::outCntT'(1)) : (creditCnt != '0);
  assign send     = validQ103H && creditOk;
  assign ready    = !validQ103H || creditOk;  // Freeze only with a record waiting

  always_ff @(posedge Clock) begin
    if (!rstN) begin
      creditCnt    <= miniCorePkg::outCntT'(miniCorePkg::OutCredits);
      resultValid  <= 1'b0;
      regWrEnQ104H <= 1'b0;
    end else begin
      resultValid <= send;                     // One cycle per record
      if (ready) regWrEnQ104H <= regWrEnQ103H;
      case ({resultValid, resultCreditReturn})
        2'b10:   creditCnt <= creditCnt - 1'b1;
        2'b01:   creditCnt <= creditCnt + 1'b1;
        default: ;                             // Spend and return cancel
      endcase
    end
  end

  // ==============================
  // Q103 to Q104 registers
  // ==============================
  always_ff @(posedge Clock) begin
    if (ready) begin
      regDstQ104H    <= regDstQ103H;
      regWrDataQ104H <= aluOutQ103H;
      resultIsBranch <= isBranchQ103H;
      resultTaken    <= branchCondMetQ103H;
    end
  end

  // Output record
  assign resultRd     = regDstQ104H;
  assign resultData   = regWrDataQ104H;
  assign resultTarget = regWrDataQ104H;  // Same word, resultIsBranch tells which

endmodule

// File: rtl/miniCoreTop.sv
`timescale 1ns/100ps
/*
  RV32I back end from Q101 decode to Q104 write-back
  Credited instruction input and credited result output
  A taken branch squashes nothing behind it
*/
module miniCoreTop (
  input  logic                 Clock,
  input  logic                 rstN,
  input  logic                 instValid,
  input  miniCorePkg::xlenT    inst,
  input  miniCorePkg::xlenT    instPc,
  output logic                 instCredit,
  output logic                 resultValid,
  output miniCorePkg::regAddrT resultRd,
  output miniCorePkg::xlenT    resultData,
  output logic                 resultIsBranch,
  output logic                 resultTaken,
  output miniCorePkg::xlenT    resultTarget,
  input  logic                 resultCreditReturn
);

  logic                  ready;
  miniCorePkg::regAddrT  rfAddr1, rfAddr2;
  miniCorePkg::xlenT     rfData1, rfData2;
  // Q102
  logic                  validQ102H, regWrEnQ102H, selAluPcQ102H, selAluImmQ102H, luiQ102H;
  miniCorePkg::xlenT     pcQ102H, immQ102H, preRegRdData1Q102H, preRegRdData2Q102H;
  miniCorePkg::regAddrT  regSrc1Q102H, regSrc2Q102H, regDstQ102H;
  miniCorePkg::aluOpT    aluOpQ102H;
  miniCorePkg::branchOpT branchOpQ102H;
  // Q103
  logic                  validQ103H, regWrEnQ103H, isBranchQ103H, branchCondMetQ103H;
  miniCorePkg::xlenT     aluOutQ103H;
  miniCorePkg::regAddrT  regDstQ103H;
  // Q104 write-back
  logic                  regWrEnQ104H;
  miniCorePkg::regAddrT  regDstQ104H;
  miniCorePkg::xlenT     regWrDataQ104H;

  miniCoreDecode uDecode (
    .Clock, .rstN, .instValid, .inst, .instPc, .ready, .rfData1, .rfData2,
    .instCredit, .rfAddr1, .rfAddr2, .validQ102H, .pcQ102H, .immQ102H,
    .preRegRdData1Q102H, .preRegRdData2Q102H, .regSrc1Q102H, .regSrc2Q102H,
    .regDstQ102H, .regWrEnQ102H, .aluOpQ102H, .branchOpQ102H,
    .selAluPcQ102H, .selAluImmQ102H, .luiQ102H
  );

  miniCoreExe uExe (
    .Clock, .rstN, .ready, .validQ102H, .pcQ102H, .immQ102H,
    .preRegRdData1Q102H, .preRegRdData2Q102H, .regSrc1Q102H, .regSrc2Q102H,
    .regDstQ102H, .regWrEnQ102H, .aluOpQ102H, .branchOpQ102H,
    .selAluPcQ102H, .selAluImmQ102H, .luiQ102H,
    .regDstQ104H, .regWrEnQ104H, .regWrDataQ104H,
    .validQ103H, .aluOutQ103H, .regDstQ103H, .regWrEnQ103H,
    .isBranchQ103H, .branchCondMetQ103H
  );

  miniCoreResult uResult (
    .Clock, .rstN, .resultCreditReturn, .validQ103H, .aluOutQ103H, .regDstQ103H,
    .regWrEnQ103H, .isBranchQ103H, .branchCondMetQ103H, .ready,
    .regDstQ104H, .regWrEnQ104H, .regWrDataQ104H, .resultValid, .resultRd,
    .resultData, .resultIsBranch, .resultTaken, .resultTarget
  );

  // Read at Q101, written from Q104
  miniCoreRegFile uRegFile (
    .Clock,
    .rstN,
    .rdAddr1 (rfAddr1),
    .rdAddr2 (rfAddr2),
    .wrEn    (regWrEnQ104H),
    .wrAddr  (regDstQ104H),
    .wrData  (regWrDataQ104H),
    .rdData1 (rfData1),
    .rdData2 (rfData2)
  );

endmodule

// File: verif/miniCoreProps.sv
`timescale 1ns/100ps
/*
  Credit and reset assertions, bound into the result stage and the decode buffer
  pulse is resultValid or instCredit
  Credit checks only apply in the result stage
*/
module miniCoreProps (
  input logic                Clock,
  input logic                rstN,
  input logic                pulse,
  input miniCorePkg::outCntT creditCnt,
  input logic                checkCredits
);

  int unsigned failCnt = 0;  // Failed assertions so far

  // Count never above its reset value
  creditMax: assert property (@(posedge Clock) disable iff (!rstN)
    checkCredits |-> (creditCnt <= miniCorePkg::outCntT'(miniCorePkg::OutCredits)))
    else begin
      failCnt++;
      $error("output credit count %0d above its limit", creditCnt);
    end

  // Record presented only with a credit to spend
  creditSpend: assert property (@(posedge Clock) disable iff (!rstN)
    (checkCredits && pulse) |-> (creditCnt != '0))
    else begin
      failCnt++;
      $error("resultValid asserted with no output credit");
    end

  // Reset value and the first clocked value out of reset
  afterReset: assert property (@(posedge Clock) $rose(rstN) |-> (!pulse ##1 !pulse))
    else begin
      failCnt++;
      $error("valid or credit pulse high right after reset");
    end

endmodule

bind miniCoreResult miniCoreProps uResultProps (
  .Clock, .rstN, .pulse(resultValid), .creditCnt, .checkCredits(1'b1)
);

bind miniCoreDecode miniCoreProps uDecodeProps (
  .Clock, .rstN, .pulse(instCredit), .creditCnt('0), .checkCredits(1'b0)
);

// File: verif/miniCoreTb.sv
`timescale 1ns/100ps
/*
  Random credited instruction stream checked against an in-order RV32I model
  Sources and destinations stay in x0 to x7 so dependences are frequent
  Branches never redirect and the PC just steps by 4
*/
module miniCoreTb;

  localparam int NumInst    = 2000;
  localparam int Seed       = 18100;
  localparam int ClkPeriod  = 10;
  localparam int WatchdogNs = NumInst * 40 * ClkPeriod;  // 40 cycles per instruction

  logic                 Clock = 1'b0;
  logic                 rstN;
  logic                 instValid, instCredit;
  miniCorePkg::xlenT    inst, instPc;
  logic                 resultValid, resultIsBranch, resultTaken, resultCreditReturn;
  miniCorePkg::regAddrT resultRd;
  miniCorePkg::xlenT    resultData, resultTarget;

  miniCorePkg::xlenT    modelRegs [32];
  logic                 expIsBranch [$];  // Expected records, program order
  logic                 expTaken [$];
  miniCorePkg::regAddrT expRd [$];
  miniCorePkg::xlenT    expValue [$];
  miniCorePkg::xlenT    nextPc;
  int                   sendCredits, numSent, held, holdOff;
  int                   mismatchErrs, protoErrs, timeoutErrs;

  miniCoreTop dut (.*);

  always #(ClkPeriod / 2) Clock = ~Clock;

  // ==============================
  // Reference model
  // ==============================
  function automatic miniCorePkg::xlenT aluRef(input logic [2:0] f3, input logic alt,
                                               input miniCorePkg::xlenT a,
                                               input miniCorePkg::xlenT b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];                     // Shift amount from low 5 bits
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? miniCorePkg::xlenT'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic modelInst(input miniCorePkg::xlenT w, input miniCorePkg::xlenT pc);
    miniCorePkg::xlenT a, b, immI, immU, immB, res;
    logic [2:0]        f3;
    logic              taken;
    a    = modelRegs[w[19:15]];
    b    = modelRegs[w[24:20]];
    f3   = w[14:12];
    immI = {{20{w[31]}}, w[31:20]};
    immU = {w[31:12], 12'b0};
    immB = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    case (w[6:0])
      miniCorePkg::OpReg:   res = aluRef(f3, w[30], a, b);
      miniCorePkg::OpImm:   res = aluRef(f3, w[30] && (f3 == 3'b101), a, immI);  // SRAI only
      miniCorePkg::OpLui:   res = immU;
      miniCorePkg::OpAuipc: res = pc + immU;
      miniCorePkg::OpBranch: begin
        case (f3)
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          3'b110:  taken = (a < b);
          default: taken = (a >= b);
        endcase
        expIsBranch.push_back(1'b1);
        expTaken.push_back(taken);
        expRd.push_back('0);
        expValue.push_back(pc + immB);  // Target, registers untouched
        return;
      end
      default: return;                  // Bubble, no record
    endcase
    if (w[11:7] != 5'd0) modelRegs[w[11:7]] = res;  // x0 stays zero
    expIsBranch.push_back(1'b0);
    expTaken.push_back(1'b0);
    expRd.push_back(w[11:7]);
    expValue.push_back(res);
  endtask

  // ==============================
  // Stimulus
  // ==============================
  function automatic miniCorePkg::xlenT randomInst();
    miniCorePkg::regAddrT rd, rs1, rs2;
    logic [2:0]           f3;
    logic [6:0]           f7;
    logic [11:0]          immI;
    logic [12:0]          immB;
    miniCorePkg::xlenT    w;
    int                   kind;
    rd   = miniCorePkg::regAddrT'($urandom_range(7));
    rs1  = miniCorePkg::regAddrT'($urandom_range(7));
    rs2  = miniCorePkg::regAddrT'($urandom_range(7));
    f3   = 3'($urandom_range(7));
    f7   = ($urandom_range(1) == 1) ? 7'h20 : 7'h00;
    immI = 12'($urandom());
    immB = 13'($urandom());
    kind = $urandom_range(99);
    if (kind < 5) begin
      case ($urandom_range(3))           // Load, store, JAL, SYSTEM
        0:       w = {25'($urandom()), 7'b0000011};
        1:       w = {25'($urandom()), 7'b0100011};
        2:       w = {25'($urandom()), 7'b1101111};
        default: w = {25'($urandom()), 7'b1110011};
      endcase
    end else if (kind < 35) begin
      if (f3 != 3'b000 && f3 != 3'b101) f7 = 7'h00;  // SUB and SRA only
      w = {f7, rs2, rs1, f3, rd, miniCorePkg::OpReg};
    end else if (kind < 62) begin
      if (f3 == 3'b001) immI[11:5] = 7'h00;
      if (f3 == 3'b101) immI[11:5] = f7;             // SRLI or SRAI
      w = {immI, rs1, f3, rd, miniCorePkg::OpImm};
    end else if (kind < 70) begin
      w = {20'($urandom()), rd, miniCorePkg::OpLui};
    end else if (kind < 78) begin
      w = {20'($urandom()), rd, miniCorePkg::OpAuipc};
    end else begin
      if (f3[2:1] == 2'b01) f3[2] = 1'b1;            // Reserved funct3 to LTU/GEU
      w = {immB[12], immB[10:5], rs2, rs1, f3, immB[4:1], immB[11], miniCorePkg::OpBranch};
    end
    return w;
  endfunction

  task automatic sendStep();
    miniCorePkg::xlenT w;
    if (instCredit) begin
      if (sendCredits == miniCorePkg::InBufDepth) begin
        protoErrs++;
        $display("instCredit pulsed with no instruction outstanding at %0t", $time);
      end else begin
        sendCredits++;
      end
    end
    instValid = 1'b0;
    if (numSent < NumInst && sendCredits > 0 && $urandom_range(99) < 70) begin
      w         = randomInst();
      inst      = w;
      instPc    = nextPc;
      instValid = 1'b1;
      modelInst(w, nextPc);
      nextPc += 4;
      numSent++;
      sendCredits--;                     // Held until the buffer frees a slot
    end
  endtask

  // ==============================
  // Checks and consumer
  // ==============================
  task automatic checkWrite(input miniCorePkg::regAddrT rd, input miniCorePkg::xlenT value);
    if (resultIsBranch !== 1'b0) begin
      mismatchErrs++;
      $display("mismatch resultIsBranch: got 0x%h, expected 0x0", resultIsBranch);
    end
    if (resultRd !== rd) begin
      mismatchErrs++;
      $display("mismatch resultRd: got 0x%h, expected 0x%h", resultRd, rd);
    end
    if (resultData !== value) begin
      mismatchErrs++;
      $display("mismatch resultData: got 0x%h, expected 0x%h", resultData, value);
    end
  endtask

  task automatic checkBranch(input logic taken, input miniCorePkg::xlenT target);
    if (resultIsBranch !== 1'b1) begin
      mismatchErrs++;
      $display("mismatch resultIsBranch: got 0x%h, expected 0x1", resultIsBranch);
    end
    if (resultTaken !== taken) begin
      mismatchErrs++;
      $display("mismatch resultTaken: got 0x%h, expected 0x%h", resultTaken, taken);
    end
    if (resultTarget !== target) begin
      mismatchErrs++;
      $display("mismatch resultTarget: got 0x%h, expected 0x%h", resultTarget, target);
    end
  endtask

  task automatic consumeStep();
    logic                 isBr, taken;
    miniCorePkg::regAddrT rd;
    miniCorePkg::xlenT    value;
    resultCreditReturn = 1'b0;
    if (resultValid) begin
      held++;
      if (held > miniCorePkg::OutCredits) begin
        protoErrs++;
        $display("more than %0d result records outstanding at %0t", held - 1, $time);
      end
      if (expRd.size() == 0) begin
        protoErrs++;
        $display("result record arrived with no instruction outstanding at %0t", $time);
      end else begin
        isBr  = expIsBranch.pop_front();
        taken = expTaken.pop_front();
        rd    = expRd.pop_front();
        value = expValue.pop_front();
        if (isBr) checkBranch(taken, value);
        else checkWrite(rd, value);
      end
    end
    if (holdOff > 0) begin
      holdOff--;                         // Withholding credits
    end else if ($urandom_range(99) < 2) begin
      holdOff = $urandom_range(120, 20);
    end else if (held > 0 && $urandom_range(99) < 50) begin
      resultCreditReturn = 1'b1;
      held--;
    end
  endtask

  // ==============================
  // Run control
  // ==============================
  task automatic finishRun();
    int assertErrs;
    assertErrs = dut.uResult.uResultProps.failCnt + dut.uDecode.uDecodeProps.failCnt;
    $display("Errors: %0d mismatch, %0d protocol, %0d assertion, %0d timeout",
             mismatchErrs, protoErrs, assertErrs, timeoutErrs);
    if (mismatchErrs + protoErrs + assertErrs + timeoutErrs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  initial begin
    void'($urandom(Seed));
    rstN               = 1'b0;
    instValid          = 1'b0;
    inst               = '0;
    instPc             = '0;
    resultCreditReturn = 1'b0;
    for (int i = 0; i < 32; i++) modelRegs[i] = '0;  // Register file clears on reset
    sendCredits  = miniCorePkg::InBufDepth;
    numSent      = 0;
    held         = 0;
    holdOff      = 0;
    mismatchErrs = 0;
    protoErrs    = 0;
    timeoutErrs  = 0;
    nextPc       = $urandom() & 32'hFFFF_FFFC;
    repeat (8) @(negedge Clock);
    rstN = 1'b1;
    // Run until every record is back and every credit returned
    while (numSent < NumInst || expRd.size() != 0 ||
           sendCredits != miniCorePkg::InBufDepth || held != 0) begin
      @(negedge Clock);
      consumeStep();
      sendStep();
    end
    finishRun();
  end

  // Watchdog
  initial begin
    #(WatchdogNs);
    timeoutErrs++;
    $display("Run timed out after %0d ns with %0d of %0d sent and %0d records pending",
             WatchdogNs, numSent, NumInst, expRd.size());
    finishRun();
  end

endmodule

// File: project.f
rtl/miniCorePkg.sv
rtl/miniCoreRegFile.sv
rtl/miniCoreDecode.sv
rtl/miniCoreExe.sv
rtl/miniCoreResult.sv
rtl/miniCoreTop.sv
verif/miniCoreProps.sv
verif/miniCoreTb.sv

// File: Bender.yml
package:
  name: mini_core

sources:
  - files:
      - rtl/miniCorePkg.sv
      - rtl/miniCoreRegFile.sv
      - rtl/miniCoreDecode.sv
      - rtl/miniCoreExe.sv
      - rtl/miniCoreResult.sv
      - rtl/miniCoreTop.sv
  - target: test
    files:
      - verif/miniCoreProps.sv
      - verif/miniCoreTb.sv
